// File: src/neoBusPkg.sv
package neoBusPkg;

	// Word address on lines 23 down to 1
	localparam int addrWidth = 23;
	localparam int dataWidth = 16;

	// Targets reachable from the 68000 side
	typedef enum logic [1:0] {
		zoneNone,
		zonePalette,
		zoneSysLatch
	} busZone;

	// Palette lives in 0x400000-0x7FFFFF and is mirrored every 8 KB
	// Only bits 23:22 take part in the decode
	localparam logic [23:0] palBase = 24'h400000;

	// System latch at 0x3A0000-0x3A001F with bits 23:5 decoded
	localparam logic [23:0] latchBase = 24'h3A0000;

	// Open bus value
	localparam logic [dataWidth-1:0] unmappedData = 16'hFFFF;

endpackage

// File: src/neoVideoPkg.sv
package neoVideoPkg;

	localparam int palIndexWidth = 12;

	// One palette entry as stored in palette RAM
	typedef struct packed {
		logic       dark;
		logic       redLow;
		logic       greenLow;
		logic       blueLow;
		logic [3:0] redHigh;
		logic [3:0] greenHigh;
		logic [3:0] blueHigh;
	} palWord;

	// Six bits per channel after dark and shadow
	typedef logic [5:0] colorLevel;

	// Pixel index in to RGB out
	localparam int videoLatency = 2;

endpackage

// File: src/cpuBusIf.sv
`timescale 1ns/10ps

// One decoded CPU access, decoder to a single target
interface cpuBusIf;

	logic                               cyc;
	logic                               stb;
	logic                               we;
	logic [1:0]                         byteSel;
	logic [neoBusPkg::addrWidth:1]      addr;
	logic [neoBusPkg::dataWidth-1:0]    wdata;
	logic [neoBusPkg::dataWidth-1:0]    rdata;
	logic                               ack;

	// Decoder side
	modport master(
		output cyc, stb, we, byteSel, addr, wdata,
		input  rdata, ack
	);

	// Target side
	modport slave(
		input  cyc, stb, we, byteSel, addr, wdata,
		output rdata, ack
	);

endinterface

// File: src/addrDecoder.sv
`timescale 1ns/10ps

module addrDecoder(
	input  logic                            clk24M,
	input  logic                            arstN,
	input  logic [neoBusPkg::addrWidth:1]   addr,
	input  logic [neoBusPkg::dataWidth-1:0] dataIn,
	input  logic                            rw,
	input  logic                            asN,
	input  logic                            ldsN,
	input  logic                            udsN,
	output logic [neoBusPkg::dataWidth-1:0] dataOut,
	output logic                            dtackN,
	cpuBusIf.master                         palBus,
	cpuBusIf.master                         latchBus
);

	typedef enum logic [2:0] {
		stIdle,
		stStrobe,
		stWaitAck,
		stDtack,
		stRelease
	} decState;

	decState state;

	// Strobe order is as, uds, lds, rw
	logic [3:0] syncA;
	logic [3:0] syncB;
	logic asS, udsS, ldsS, rwS;

	neoBusPkg::busZone addrZone;
	neoBusPkg::busZone cycZone;

	logic [neoBusPkg::addrWidth:1]   cycAddr;
	logic [neoBusPkg::dataWidth-1:0] cycData;
	logic                            cycWe;
	logic [1:0]                      cycSel;
	logic                            cycActive;
	logic                            targetAck;

	assign {asS, udsS, ldsS, rwS} = syncB;

	// Mirrors of the palette fall out of decoding only the top two lines
	always_comb begin
		addrZone = neoBusPkg::zoneNone;
		if (addr[23:22] == neoBusPkg::palBase[23:22])
			addrZone = neoBusPkg::zonePalette;
		else if (addr[23:5] == neoBusPkg::latchBase[23:5])
			addrZone = neoBusPkg::zoneSysLatch;
	end

	assign cycActive = (state == stStrobe) || (state == stWaitAck);

	assign palBus.cyc     = cycActive && (cycZone == neoBusPkg::zonePalette);
	assign palBus.stb     = cycActive && (cycZone == neoBusPkg::zonePalette);
	assign palBus.we      = cycWe;
	assign palBus.byteSel = cycSel;
	assign palBus.addr    = cycAddr;
	assign palBus.wdata   = cycData;

	assign latchBus.cyc     = cycActive && (cycZone == neoBusPkg::zoneSysLatch);
	assign latchBus.stb     = cycActive && (cycZone == neoBusPkg::zoneSysLatch);
	assign latchBus.we      = cycWe;
	assign latchBus.byteSel = cycSel;
	assign latchBus.addr    = cycAddr;
	assign latchBus.wdata   = cycData;

	// Unmapped zones answer at the slot where a target ack would land
	always_comb begin
		case (cycZone)
			neoBusPkg::zonePalette:  targetAck = palBus.ack;
			neoBusPkg::zoneSysLatch: targetAck = latchBus.ack;
			default:                 targetAck = 1'b1;
		endcase
	end

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			syncA   <= 4'b1111;
			syncB   <= 4'b1111;
			state   <= stIdle;
			cycZone <= neoBusPkg::zoneNone;
			dtackN  <= 1'b1;
		end else begin
			syncA <= {asN, udsN, ldsN, rw};
			syncB <= syncA;
			case (state)
				stIdle: begin
					if (!asS) begin
						cycZone <= addrZone;
						state   <= stStrobe;
					end
				end
				stStrobe:
					state <= stWaitAck;
				stWaitAck: begin
					if (targetAck) begin
						dtackN <= 1'b0;
						state  <= stDtack;
					end
				end
				stDtack: begin
					// Hold DTACK until the CPU ends its cycle
					if (asS) begin
						dtackN <= 1'b1;
						state  <= stRelease;
					end
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Cycle payload is captured once per access
	always_ff @(posedge clk24M) begin
		if (state == stIdle && !asS) begin
			cycAddr <= addr;
			cycData <= dataIn;
			cycWe   <= ~rwS;
			cycSel  <= ~{udsS, ldsS};
		end
		if (state == stWaitAck && targetAck) begin
			case (cycZone)
				neoBusPkg::zonePalette:  dataOut <= palBus.rdata;
				neoBusPkg::zoneSysLatch: dataOut <= latchBus.rdata;
				default:                 dataOut <= neoBusPkg::unmappedData;
			endcase
		end
	end

endmodule

// File: src/sysLatch.sv
`timescale 1ns/10ps

module sysLatch(
	input  logic       clk24M,
	input  logic       arstN,
	cpuBusIf.slave     bus,
	output logic [7:0] latchBits,
	output logic       shadow,
	output logic       palBank
);

	logic writeHit;

	// Data lines play no part in an addressable latch write
	assign writeHit = bus.cyc && bus.stb && bus.we && !bus.ack;

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN) begin
			latchBits <= '0;
			bus.ack   <= 1'b0;
		end else begin
			bus.ack <= bus.cyc && bus.stb && !bus.ack;
			// Line 4 carries the value, lines 3:1 pick the bit
			if (writeHit)
				latchBits[bus.addr[3:1]] <= bus.addr[4];
		end
	end

	// Upper byte floats high on the real board
	assign bus.rdata = {{(neoBusPkg::dataWidth - 8){1'b1}}, latchBits};

	// Bits 1 to 6 are vector, card and system selects
	assign shadow  = latchBits[0];
	assign palBank = latchBits[7];

endmodule

// File: src/paletteRam.sv
`timescale 1ns/10ps

module paletteRam(
	input  logic                                   clk24M,
	cpuBusIf.slave                                 bus,
	input  logic                                   palBank,
	input  logic [neoVideoPkg::palIndexWidth-1:0]  videoIndex,
	input  logic                                   videoRead,
	output neoVideoPkg::palWord                    videoData
);

	localparam int ramAddrWidth = neoVideoPkg::palIndexWidth + 1;

	logic [neoBusPkg::dataWidth-1:0] mem [0:(1 << ramAddrWidth) - 1];

	logic [ramAddrWidth-1:0] cpuAddr;
	logic [ramAddrWidth-1:0] videoAddr;
	logic                    cpuHit;

	// Bank bit on top of the word index
	assign cpuAddr   = {palBank, bus.addr[12:1]};
	assign videoAddr = {palBank, videoIndex};

	assign cpuHit = bus.cyc && bus.stb && !bus.ack;

	// Ack pulses once for each new strobe
	always_ff @(posedge clk24M) begin
		bus.ack <= cpuHit;
	end

	// CPU port
	always_ff @(posedge clk24M) begin
		if (cpuHit) begin
			if (bus.we && bus.byteSel[1])
				mem[cpuAddr][15:8] <= bus.wdata[15:8];
			if (bus.we && bus.byteSel[0])
				mem[cpuAddr][7:0] <= bus.wdata[7:0];
			bus.rdata <= mem[cpuAddr];
		end
	end

	// Video port reads in one cycle
	always_ff @(posedge clk24M) begin
		if (videoRead)
			videoData <= mem[videoAddr];
	end

endmodule

// File: src/videoOut.sv
`timescale 1ns/10ps

module videoOut(
	input  logic                                  clk24M,
	input  logic                                  arstN,
	input  logic [neoVideoPkg::palIndexWidth-1:0] pixIndex,
	input  logic                                  pixValid,
	input  logic                                  shadow,
	output logic [neoVideoPkg::palIndexWidth-1:0] videoIndex,
	output logic                                  videoRead,
	input  neoVideoPkg::palWord                   videoData,
	output neoVideoPkg::colorLevel                red,
	output neoVideoPkg::colorLevel                green,
	output neoVideoPkg::colorLevel                blue,
	output logic                                  rgbValid
);

	logic [neoVideoPkg::videoLatency-1:0] validPipe;

	// Five color bits, then the inverted dark bit as LSB
	function automatic neoVideoPkg::colorLevel shade(
		input logic [3:0] high,
		input logic       low,
		input logic       dark,
		input logic       halve
	);
		neoVideoPkg::colorLevel level;
		level = {high, low, ~dark};
		if (halve)
			level = level >> 1;
		return level;
	endfunction

	// Palette lookup is the first pipeline stage
	assign videoIndex = pixIndex;
	assign videoRead  = pixValid;

	always_ff @(posedge clk24M or negedge arstN) begin
		if (!arstN)
			validPipe <= '0;
		else
			validPipe <= {validPipe[neoVideoPkg::videoLatency-2:0], pixValid};
	end

	assign rgbValid = validPipe[neoVideoPkg::videoLatency-1];

	always_ff @(posedge clk24M) begin
		if (validPipe[0]) begin
			red   <= shade(videoData.redHigh, videoData.redLow, videoData.dark, shadow);
			green <= shade(videoData.greenHigh, videoData.greenLow, videoData.dark, shadow);
			blue  <= shade(videoData.blueHigh, videoData.blueLow, videoData.dark, shadow);
		end
	end

endmodule

// File: src/neoSystem.sv
`timescale 1ns/10ps

module neoSystem(
	input  logic                                  clk24M,
	input  logic                                  arstN,

	// 68K side
	input  logic [neoBusPkg::addrWidth:1]         addr,
	input  logic [neoBusPkg::dataWidth-1:0]       dataIn,
	output logic [neoBusPkg::dataWidth-1:0]       dataOut,
	input  logic                                  rw,
	input  logic                                  asN,
	input  logic                                  ldsN,
	input  logic                                  udsN,
	output logic                                  dtackN,

	// Pixel stream from the sprite and fix engine
	input  logic [neoVideoPkg::palIndexWidth-1:0] pixIndex,
	input  logic                                  pixValid,
	output neoVideoPkg::colorLevel                red,
	output neoVideoPkg::colorLevel                green,
	output neoVideoPkg::colorLevel                blue,
	output logic                                  rgbValid
);

	cpuBusIf palBus();
	cpuBusIf latchBus();

	logic                                  shadow;
	logic                                  palBank;
	logic [neoVideoPkg::palIndexWidth-1:0] videoIndex;
	logic                                  videoRead;
	neoVideoPkg::palWord                   videoData;

	addrDecoder decoder(
		.clk24M   (clk24M),
		.arstN    (arstN),
		.addr     (addr),
		.dataIn   (dataIn),
		.rw       (rw),
		.asN      (asN),
		.ldsN     (ldsN),
		.udsN     (udsN),
		.dataOut  (dataOut),
		.dtackN   (dtackN),
		.palBus   (palBus.master),
		.latchBus (latchBus.master)
	);

	// Raw latch byte is only needed on the bus read path
	sysLatch latch(
		.clk24M    (clk24M),
		.arstN     (arstN),
		.bus       (latchBus.slave),
		.latchBits (),
		.shadow    (shadow),
		.palBank   (palBank)
	);

	paletteRam palRam(
		.clk24M     (clk24M),
		.bus        (palBus.slave),
		.palBank    (palBank),
		.videoIndex (videoIndex),
		.videoRead  (videoRead),
		.videoData  (videoData)
	);

	videoOut vout(
		.clk24M     (clk24M),
		.arstN      (arstN),
		.pixIndex   (pixIndex),
		.pixValid   (pixValid),
		.shadow     (shadow),
		.videoIndex (videoIndex),
		.videoRead  (videoRead),
		.videoData  (videoData),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.rgbValid   (rgbValid)
	);

endmodule

// File: testbench/neoSystem_assertions.sv
`timescale 1ns/10ps

module neoSystemAssertions(
	input logic clk24M,
	input logic arstN,
	input logic asN,
	input logic dtackN,
	input logic palStb,
	input logic palAck,
	input logic latchStb,
	input logic latchAck,
	input logic pixValid,
	input logic rgbValid
);

	int failCount = 0;

	// DTACK holds while the CPU keeps its strobe low
	dtackHold: assert property (@(posedge clk24M) disable iff (!arstN)
		(!dtackN && !asN) |=> !dtackN)
		else begin
			$error("dtackN released while asN still low");
			failCount++;
		end

	// Target acks once a cycle after the strobe, then the decoder drops it
	palAckPulse: assert property (@(posedge clk24M) disable iff (!arstN)
		$rose(palStb) |=> palAck ##1 (!palAck && !palStb))
		else begin
			$error("palette ack not a single pulse one cycle after strobe");
			failCount++;
		end

	latchAckPulse: assert property (@(posedge clk24M) disable iff (!arstN)
		$rose(latchStb) |=> latchAck ##1 (!latchAck && !latchStb))
		else begin
			$error("latch ack not a single pulse one cycle after strobe");
			failCount++;
		end

	// Output trails input by two clocks with two pixels in flight
	rgbFollows: assert property (@(posedge clk24M) disable iff (!arstN)
		pixValid |-> ##2 rgbValid)
		else begin
			$error("rgbValid missing two cycles after pixValid");
			failCount++;
		end

	rgbQuiet: assert property (@(posedge clk24M) disable iff (!arstN)
		!pixValid |-> ##2 !rgbValid)
		else begin
			$error("rgbValid without a pixel two cycles earlier");
			failCount++;
		end

endmodule

bind neoSystem neoSystemAssertions busChecks(
	.clk24M   (clk24M),
	.arstN    (arstN),
	.asN      (asN),
	.dtackN   (dtackN),
	.palStb   (palBus.stb),
	.palAck   (palBus.ack),
	.latchStb (latchBus.stb),
	.latchAck (latchBus.ack),
	.pixValid (pixValid),
	.rgbValid (rgbValid)
);

// File: testbench/neoSystemTb.sv
`timescale 1ns/10ps

module neoSystemTb;

	localparam int timeoutCycles = 50;
	localparam int latency = 2;

	logic        clk24M;
	logic        arstN;
	logic [23:1] addr;
	logic [15:0] dataIn;
	logic [15:0] dataOut;
	logic        rw;
	logic        asN;
	logic        ldsN;
	logic        udsN;
	logic        dtackN;
	logic [11:0] pixIndex;
	logic        pixValid;
	logic [5:0]  red;
	logic [5:0]  green;
	logic [5:0]  blue;
	logic        rgbValid;

	int seed = 6104;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int cycleCount = 0;

	// Reference state of the palette and the latch
	logic [15:0] palModel [0:8191];
	logic [7:0]  latchModel = 8'h00;
	logic [11:0] written[$];

	// Pending pixels, expected RGB and the falling edge it must show on
	logic [17:0] expRgb[$];
	int          expDue[$];

	neoSystem UUT(
		.clk24M   (clk24M),
		.arstN    (arstN),
		.addr     (addr),
		.dataIn   (dataIn),
		.dataOut  (dataOut),
		.rw       (rw),
		.asN      (asN),
		.ldsN     (ldsN),
		.udsN     (udsN),
		.dtackN   (dtackN),
		.pixIndex (pixIndex),
		.pixValid (pixValid),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.rgbValid (rgbValid)
	);

	initial begin
		clk24M = 1'b0;
		forever #5 clk24M = ~clk24M;
	end

	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	// Each channel is high nibble, low bit, then not dark; shadow halves it
	function automatic logic [17:0] colorOf(input logic [15:0] word, input logic shade);
		int level[3];
		for (int c = 0; c < 3; c++) begin
			level[c] = int'(word[11 - 4*c -: 4]) * 4 + int'(word[14 - c]) * 2;
			level[c] = level[c] + (word[15] ? 0 : 1);
			if (shade)
				level[c] = level[c] / 2;
		end
		return {6'(level[0]), 6'(level[1]), 6'(level[2])};
	endfunction

	// Any 8 KB mirror in 0x400000-0x7FFFFF
	function automatic logic [23:0] palAddr(input logic [11:0] index);
		logic [31:0] mirror;
		mirror = nextRandom();
		return {2'b01, mirror[8:0], index, 1'b0};
	endfunction

	function automatic logic [11:0] pickWritten();
		return written[$unsigned(nextRandom()) % written.size()];
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			testErrors++;
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic finishTest(input string name);
		$display("test %-12s %s, %0d errors", name, testErrors == 0 ? "ok" : "failed",
			testErrors);
		testErrors = 0;
	endtask

	task automatic busAccess(input logic [23:0] byteAddr, input logic write,
			input logic [1:0] lanes, input logic [15:0] wdata, output logic [15:0] rdata);
		int waitCount;
		@(posedge clk24M);
		addr   <= byteAddr[23:1];
		dataIn <= wdata;
		rw     <= ~write;
		udsN   <= ~lanes[1];
		ldsN   <= ~lanes[0];
		asN    <= 1'b0;
		waitCount = 0;
		do begin
			@(posedge clk24M);
			waitCount++;
			if (waitCount > timeoutCycles)
				abortRun("timeout: dtackN never went low");
		end while (dtackN !== 1'b0);
		// Seen one edge after it fell
		checkValue("dtackN latency", waitCount - 1, 5);
		rdata = dataOut;
		asN  <= 1'b1;
		udsN <= 1'b1;
		ldsN <= 1'b1;
		rw   <= 1'b1;
		waitCount = 0;
		while (dtackN !== 1'b1) begin
			@(posedge clk24M);
			waitCount++;
			if (waitCount > timeoutCycles)
				abortRun("timeout: dtackN stayed low after asN rose");
		end
	endtask

	task automatic busWrite(input logic [23:0] byteAddr, input logic [1:0] lanes,
			input logic [15:0] wdata);
		logic [15:0] ignored;
		busAccess(byteAddr, 1'b1, lanes, wdata, ignored);
	endtask

	task automatic busRead(input logic [23:0] byteAddr, output logic [15:0] rdata);
		busAccess(byteAddr, 1'b0, 2'b11, 16'h0000, rdata);
	endtask

	task automatic palWrite(input logic [11:0] index, input logic [1:0] lanes,
			input logic [15:0] data);
		busWrite(palAddr(index), lanes, data);
		if (lanes[1])
			palModel[{latchModel[7], index}][15:8] = data[15:8];
		if (lanes[0])
			palModel[{latchModel[7], index}][7:0] = data[7:0];
	endtask

	task automatic checkPalette(input logic [11:0] index);
		logic [15:0] rdata;
		busRead(palAddr(index), rdata);
		checkValue("dataOut", rdata, palModel[{latchModel[7], index}]);
	endtask

	// Line 4 is the value and lines 3:1 the bit, with random noise on the data bus
	task automatic latchWrite(input logic [2:0] bitSel, input logic value);
		busWrite(24'h3A0000 | 24'({value, bitSel, 1'b0}), 2'b11, 16'(nextRandom()));
		latchModel[bitSel] = value;
	endtask

	task automatic checkLatch();
		logic [15:0] rdata;
		busRead(24'h3A0000, rdata);
		checkValue("dataOut", rdata, {8'hFF, latchModel});
	endtask

	task automatic streamPixels(input int count);
		logic [11:0] index;
		int waitCount;
		for (int i = 0; i < count; i++) begin
			@(posedge clk24M);
			index = pickWritten();
			pixIndex <= index;
			pixValid <= 1'b1;
			expRgb.push_back(colorOf(palModel[{latchModel[7], index}], latchModel[0]));
			// RGB shows two edges after the index is sampled
			expDue.push_back(cycleCount + 1 + latency);
		end
		@(posedge clk24M);
		pixValid <= 1'b0;
		waitCount = 0;
		while (expRgb.size() != 0) begin
			@(posedge clk24M);
			waitCount++;
			if (waitCount > timeoutCycles)
				abortRun("timeout: RGB output stopped before all pixels came back");
		end
	endtask

	// Video compare runs on the falling edge where outputs are settled
	always @(negedge clk24M) begin
		cycleCount++;
		if (rgbValid === 1'b1) begin
			if (expRgb.size() == 0) begin
				errors++;
				testErrors++;
				$display("rgbValid raised with no pixel pending");
			end else begin
				checkValue("red/green/blue", {red, green, blue}, expRgb.pop_front());
				checkValue("rgbValid cycle", cycleCount, expDue.pop_front());
			end
		end
	end

	initial begin
		logic [15:0] rdata;
		logic [31:0] data32;
		logic [11:0] index;

		arstN    = 1'b0;
		addr     = '0;
		dataIn   = '0;
		rw       = 1'b1;
		asN      = 1'b1;
		ldsN     = 1'b1;
		udsN     = 1'b1;
		pixIndex = '0;
		pixValid = 1'b0;
		repeat (5) @(posedge clk24M);
		arstN <= 1'b1;

		checkLatch();
		finishTest("latchReset");

		for (int i = 0; i < 24; i++) begin
			index = 12'(nextRandom());
			palWrite(index, 2'b11, 16'(nextRandom()));
			written.push_back(index);
		end
		foreach (written[i])
			checkPalette(written[i]);
		for (int i = 0; i < 8; i++) begin
			index = pickWritten();
			palWrite(index, i[0] ? 2'b10 : 2'b01, 16'(nextRandom()));
			checkPalette(index);
		end
		finishTest("paletteWords");

		for (int i = 0; i < 16; i++) begin
			data32 = nextRandom();
			latchWrite(data32[2:0], data32[3]);
			checkLatch();
		end
		for (int b = 0; b < 8; b++)
			latchWrite(3'(b), 1'b0);
		checkLatch();
		finishTest("latchBits");

		// Bank 1 writes reuse bank 0 indexes so a missed bank bit shows below
		latchWrite(3'd7, 1'b1);
		for (int i = 0; i < 8; i++) begin
			index = pickWritten();
			palWrite(index, 2'b11, 16'(nextRandom()));
			checkPalette(index);
		end
		latchWrite(3'd7, 1'b0);
		foreach (written[i])
			checkPalette(written[i]);
		finishTest("paletteBank");

		streamPixels(32);
		latchWrite(3'd0, 1'b1);
		streamPixels(32);
		latchWrite(3'd0, 1'b0);
		finishTest("videoStream");

		for (int i = 0; i < 6; i++) begin
			data32 = nextRandom();
			busRead({4'h2, data32[18:0], 1'b0}, rdata);
			checkValue("dataOut", rdata, 16'hFFFF);
			busWrite({4'h1, data32[18:0], 1'b0}, 2'b11, 16'(nextRandom()));
		end
		checkLatch();
		for (int i = 0; i < 6; i++)
			checkPalette(pickWritten());
		finishTest("unmapped");

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			UUT.busChecks.failCount);
		if (errors == 0 && UUT.busChecks.failCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: sim.f
src/neoBusPkg.sv
src/neoVideoPkg.sv
src/cpuBusIf.sv
src/addrDecoder.sv
src/sysLatch.sv
src/paletteRam.sv
src/videoOut.sv
src/neoSystem.sv
testbench/neoSystem_assertions.sv
testbench/neoSystemTb.sv

// File: Bender.yml
package:
  name: neo_system

sources:
  - files:
      - src/neoBusPkg.sv
      - src/neoVideoPkg.sv
      - src/cpuBusIf.sv
      - src/addrDecoder.sv
      - src/sysLatch.sv
      - src/paletteRam.sv
      - src/videoOut.sv
      - src/neoSystem.sv
  - target: test
    files:
      - testbench/neoSystem_assertions.sv
      - testbench/neoSystemTb.sv
